// ==== compile.f ====
source/csr_pkg.sv
source/csr_write_ctrl.sv
source/csr_counter64.sv
source/csr_trap_regs.sv
source/csr_irq_ctrl.sv
source/csr_read_mux.sv
source/csr_bank_top.sv
testbench/csr_bank_chk.sv
testbench/tb_csr_bank.sv

// ==== run.sh ====
#!/bin/sh
# Build the CSR bank testbench with Verilator, run it and scan the log
set -e

verilator --binary --timing --assert -j 0 \
    --top-module tb_csr_bank \
    -f compile.f \
    -o sim_csr_bank

# Bound assertion errors are tallied by the testbench, so the run must go on past them
./obj_dir/sim_csr_bank +verilator+error+limit+1000 > sim.log 2>&1 || {
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
}
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
echo "Simulation log is clean"

// ==== source/csr_bank_top.sv ====
// Machine-mode CSR bank top level with its pair of 64-bit counters
`timescale 1ns/1ns

module csr_bank_top
    import csr_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      read_enable_i,
    input  logic      write_enable_i,
    input  csr_op_e   operation_i,
    input  csr_addr_t address_i,
    input  xlen_t     data_i,
    input  logic      kill_i,
    input  logic      raise_exception_i,
    input  exc_code_t exception_code_i,
    input  xlen_t     pc_i,
    input  xlen_t     instruction_i,
    input  logic      machine_return_i,
    input  logic      interrupt_ack_i,
    input  logic      jump_i,
    input  xlen_t     jump_target_i,
    input  dword_t    mtime_i,
    input  xlen_t     irq_i,
    output xlen_t     read_data_o,
    output logic      interrupt_pending_o,
    output priv_e     privilege_o,
    output xlen_t     mtvec_o,
    output xlen_t     mepc_o
);

    wr_strobe_t              wr_strobe;
    logic [NUM_COUNTERS-1:0] cnt_wr_lo, cnt_wr_hi;
    xlen_t                   wr_data, current;
    xlen_t                   mstatus, misa, mie, mscratch, mcause, mtval, mip;
    exc_code_t               irq_code;
    dword_t                  count [NUM_COUNTERS];

    csr_write_ctrl u_write_ctrl (
        .write_enable_i, .kill_i, .operation_i, .address_i, .data_i,
        .current_i    (current),
        .trap_event_i (machine_return_i | raise_exception_i | interrupt_ack_i),
        .wr_strobe_o  (wr_strobe),
        .cnt_wr_lo_o  (cnt_wr_lo),
        .cnt_wr_hi_o  (cnt_wr_hi),
        .wr_data_o    (wr_data)
    );

    // Cycle counts every clock, instret only for instructions not killed
    for (genvar g = 0; g < NUM_COUNTERS; g++) begin : g_counter
        csr_counter64 u_counter (
            .clk_i, .reset_i,
            .inc_i     ((g == CNT_CYCLE) ? 1'b1 : !kill_i),
            .wr_lo_i   (cnt_wr_lo[g]),
            .wr_hi_i   (cnt_wr_hi[g]),
            .wr_data_i (wr_data),
            .count_o   (count[g])
        );
    end

    csr_trap_regs u_trap_regs (
        .clk_i, .reset_i, .machine_return_i, .raise_exception_i, .exception_code_i,
        .pc_i, .instruction_i, .interrupt_ack_i, .jump_i, .jump_target_i,
        .wr_strobe_i (wr_strobe),  .wr_data_i  (wr_data),   .irq_code_i (irq_code),
        .mstatus_o   (mstatus),    .misa_o     (misa),      .mie_o      (mie),
        .mtvec_o,                  .mscratch_o (mscratch),  .mepc_o,
        .mcause_o    (mcause),     .mtval_o    (mtval),     .privilege_o
    );

    csr_irq_ctrl u_irq_ctrl (
        .clk_i, .reset_i, .irq_i, .interrupt_ack_i,
        .global_ie_i (mstatus[BIT_MIE]),
        .mie_i       (mie),
        .mip_o       (mip),
        .pending_o   (interrupt_pending_o),
        .irq_code_o  (irq_code)
    );

    csr_read_mux u_read_mux (
        .read_enable_i, .kill_i, .address_i, .mtime_i, .read_data_o,
        .mstatus_i (mstatus),  .misa_i     (misa),     .mie_i     (mie),
        .mtvec_i   (mtvec_o),  .mscratch_i (mscratch), .mepc_i    (mepc_o),
        .mcause_i  (mcause),   .mtval_i    (mtval),    .mip_i     (mip),
        .cycle_i   (count[CNT_CYCLE]),
        .instret_i (count[CNT_INSTRET]),
        .current_o (current)
    );

endmodule

// ==== source/csr_counter64.sv ====
// 64-bit counter with separate loads of the low and high halves
`timescale 1ns/1ns

module csr_counter64
    import csr_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   inc_i,
    input  logic   wr_lo_i,
    input  logic   wr_hi_i,
    input  xlen_t  wr_data_i,
    output dword_t count_o
);

    dword_t count_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (wr_lo_i || wr_hi_i) begin
            // Loaded half takes the data, the other one holds
            if (wr_lo_i) begin
                count_q[31:0] <= wr_data_i;
            end
            if (wr_hi_i) begin
                count_q[63:32] <= wr_data_i;
            end
        end else if (inc_i) begin
            count_q <= count_q + 64'd1;
        end
    end

    assign count_o = count_q;

endmodule

// ==== source/csr_irq_ctrl.sv ====
// Registered mip, interrupt pending flag and prioritized cause code
`timescale 1ns/1ns

module csr_irq_ctrl
    import csr_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  xlen_t     irq_i,
    input  logic      global_ie_i,
    input  xlen_t     mie_i,
    input  logic      interrupt_ack_i,
    output xlen_t     mip_o,
    output logic      pending_o,
    output exc_code_t irq_code_o
);

    xlen_t     mip_q;
    xlen_t     active;
    logic      take;
    logic      pending_q;
    exc_code_t code_q;

    assign active = mie_i & mip_q;
    assign take   = global_ie_i && (active != '0) && !interrupt_ack_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mip_q     <= '0;
            pending_q <= 1'b0;
            code_q    <= '0;
        end else begin
            mip_q     <= irq_i;   // One cycle of sampling
            pending_q <= take;
            if (take) begin
                if (active[IRQ_EXT]) begin
                    code_q <= IRQ_EXT;
                end else if (active[IRQ_SW]) begin
                    code_q <= IRQ_SW;
                end else if (active[IRQ_TIMER]) begin
                    code_q <= IRQ_TIMER;
                end
            end
        end
    end

    assign mip_o      = mip_q;
    assign pending_o  = pending_q;
    assign irq_code_o = code_q;

endmodule

// ==== source/csr_pkg.sv ====
// Shared widths, types, CSR addresses, write masks, reset values and cause codes
package csr_pkg;

    typedef logic [31:0] xlen_t;      // CSR word and program counter
    typedef logic [63:0] dword_t;     // Counters and mtime
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  exc_code_t;  // Exception or interrupt cause

    // Encoding follows the low bits of the CSR funct3 field
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Machine trap setup and handling
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;

    // Machine counters
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;

    // User read-only aliases
    localparam csr_addr_t ADDR_CYCLE     = 12'hC00;
    localparam csr_addr_t ADDR_TIME      = 12'hC01;
    localparam csr_addr_t ADDR_INSTRET   = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
    localparam csr_addr_t ADDR_TIMEH     = 12'hC81;
    localparam csr_addr_t ADDR_INSTRETH  = 12'hC82;

    localparam xlen_t MASK_MSTATUS = 32'h007E19AA;
    localparam xlen_t MASK_MISA    = 32'h3C000000;
    localparam xlen_t MASK_MIE     = 32'h00000888;
    localparam xlen_t MASK_ALIGN   = 32'hFFFFFFFC;  // mtvec and mepc
    localparam xlen_t MASK_FULL    = 32'hFFFFFFFF;
    localparam xlen_t MISA_RESET   = 32'h40000100;  // RV32I

    localparam exc_code_t EXC_ILLEGAL    = 5'd2;
    localparam exc_code_t EXC_BREAKPOINT = 5'd3;
    localparam exc_code_t EXC_ECALL_M    = 5'd11;
    localparam exc_code_t IRQ_SW         = 5'd3;
    localparam exc_code_t IRQ_TIMER      = 5'd7;
    localparam exc_code_t IRQ_EXT        = 5'd11;

    localparam int BIT_MIE  = 3;
    localparam int BIT_MPIE = 7;
    localparam int MPP_LO   = 11;   // MPP occupies two bits from here

    // Write strobe index of each trap register
    localparam int WR_MSTATUS    = 0;
    localparam int WR_MISA       = 1;
    localparam int WR_MIE        = 2;
    localparam int WR_MTVEC      = 3;
    localparam int WR_MSCRATCH   = 4;
    localparam int WR_MEPC       = 5;
    localparam int WR_MCAUSE     = 6;
    localparam int WR_MTVAL      = 7;
    localparam int NUM_TRAP_REGS = 8;

    typedef logic [NUM_TRAP_REGS-1:0] wr_strobe_t;

    localparam int NUM_COUNTERS = 2;
    localparam int CNT_CYCLE    = 0;
    localparam int CNT_INSTRET  = 1;

endpackage

// ==== source/csr_read_mux.sv ====
// CSR read selection with raw current value and gated read data
`timescale 1ns/1ns

module csr_read_mux
    import csr_pkg::*;
(
    input  logic      read_enable_i,
    input  logic      kill_i,
    input  csr_addr_t address_i,
    input  xlen_t     mstatus_i,
    input  xlen_t     misa_i,
    input  xlen_t     mie_i,
    input  xlen_t     mtvec_i,
    input  xlen_t     mscratch_i,
    input  xlen_t     mepc_i,
    input  xlen_t     mcause_i,
    input  xlen_t     mtval_i,
    input  xlen_t     mip_i,
    input  dword_t    cycle_i,
    input  dword_t    instret_i,
    input  dword_t    mtime_i,
    output xlen_t     current_o,
    output xlen_t     read_data_o
);

    always_comb begin
        case (address_i)
            ADDR_MSTATUS:   current_o = mstatus_i;
            ADDR_MISA:      current_o = misa_i;
            ADDR_MIE:       current_o = mie_i;
            ADDR_MTVEC:     current_o = mtvec_i;
            ADDR_MSCRATCH:  current_o = mscratch_i;
            ADDR_MEPC:      current_o = mepc_i;
            ADDR_MCAUSE:    current_o = mcause_i;
            ADDR_MTVAL:     current_o = mtval_i;
            ADDR_MIP:       current_o = mip_i;
            ADDR_MCYCLE,
            ADDR_CYCLE:     current_o = cycle_i[31:0];
            ADDR_MCYCLEH,
            ADDR_CYCLEH:    current_o = cycle_i[63:32];
            ADDR_MINSTRET,
            ADDR_INSTRET:   current_o = instret_i[31:0];
            ADDR_MINSTRETH,
            ADDR_INSTRETH:  current_o = instret_i[63:32];
            ADDR_TIME:      current_o = mtime_i[31:0];
            ADDR_TIMEH:     current_o = mtime_i[63:32];
            default:        current_o = '0;   // Unimplemented CSR
        endcase
    end

    // Killed or disabled reads return zero
    assign read_data_o = (read_enable_i && !kill_i) ? current_o : '0;

endmodule

// ==== source/csr_trap_regs.sv ====
// Machine status and trap registers with the privilege level state
`timescale 1ns/1ns

module csr_trap_regs
    import csr_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  wr_strobe_t wr_strobe_i,
    input  xlen_t      wr_data_i,
    input  logic       machine_return_i,
    input  logic       raise_exception_i,
    input  exc_code_t  exception_code_i,
    input  xlen_t      pc_i,
    input  xlen_t      instruction_i,
    input  logic       interrupt_ack_i,
    input  exc_code_t  irq_code_i,
    input  logic       jump_i,
    input  xlen_t      jump_target_i,
    output xlen_t      mstatus_o,
    output xlen_t      misa_o,
    output xlen_t      mie_o,
    output xlen_t      mtvec_o,
    output xlen_t      mscratch_o,
    output xlen_t      mepc_o,
    output xlen_t      mcause_o,
    output xlen_t      mtval_o,
    output priv_e      privilege_o
);

    xlen_t mstatus_q, misa_q, mie_q, mtvec_q;
    xlen_t mscratch_q, mepc_q, mcause_q, mtval_q;
    priv_e privilege_q;
    logic  trap_entry;

    assign trap_entry = raise_exception_i || interrupt_ack_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mstatus_q   <= '0;
            misa_q      <= MISA_RESET;
            mie_q       <= '0;
            mtvec_q     <= '0;
            mscratch_q  <= '0;
            mepc_q      <= '0;
            mcause_q    <= '0;
            mtval_q     <= '0;
            privilege_q <= PRIV_MACHINE;
        end else if (machine_return_i) begin
            mstatus_q[BIT_MIE] <= mstatus_q[BIT_MPIE];
            privilege_q        <= priv_e'(mstatus_q[MPP_LO +: 2]);
        end else if (trap_entry) begin
            // Status stacking is common to exceptions and interrupts
            mstatus_q[MPP_LO +: 2] <= privilege_q;
            mstatus_q[BIT_MPIE]    <= mstatus_q[BIT_MIE];
            mstatus_q[BIT_MIE]     <= 1'b0;
            privilege_q            <= PRIV_MACHINE;
            if (raise_exception_i) begin
                mcause_q <= {27'b0, exception_code_i};   // Bit 31 clear
                if (exception_code_i == EXC_ECALL_M || exception_code_i == EXC_BREAKPOINT) begin
                    mepc_q <= pc_i;
                end else begin
                    mepc_q <= pc_i + 32'd4;
                end
                mtval_q <= (exception_code_i == EXC_ILLEGAL) ? instruction_i : pc_i;
            end else begin
                mcause_q <= {1'b1, 26'b0, irq_code_i};
                mepc_q   <= jump_i ? jump_target_i : pc_i;   // Resume at taken branch
            end
        end else begin
            if (wr_strobe_i[WR_MSTATUS]) begin
                mstatus_q <= wr_data_i;
            end
            if (wr_strobe_i[WR_MISA]) begin
                misa_q <= wr_data_i;
            end
            if (wr_strobe_i[WR_MIE]) begin
                mie_q <= wr_data_i;
            end
            if (wr_strobe_i[WR_MTVEC]) begin
                mtvec_q <= wr_data_i;
            end
            if (wr_strobe_i[WR_MSCRATCH]) begin
                mscratch_q <= wr_data_i;
            end
            if (wr_strobe_i[WR_MEPC]) begin
                mepc_q <= wr_data_i;
            end
            if (wr_strobe_i[WR_MCAUSE]) begin
                mcause_q <= wr_data_i;
            end
            if (wr_strobe_i[WR_MTVAL]) begin
                mtval_q <= wr_data_i;
            end
        end
    end

    assign mstatus_o   = mstatus_q;
    assign misa_o      = misa_q;
    assign mie_o       = mie_q;
    assign mtvec_o     = mtvec_q;
    assign mscratch_o  = mscratch_q;
    assign mepc_o      = mepc_q;
    assign mcause_o    = mcause_q;
    assign mtval_o     = mtval_q;
    assign privilege_o = privilege_q;

endmodule

// ==== source/csr_write_ctrl.sv ====
// CSR address decode, write strobes and masked write, set and clear data
`timescale 1ns/1ns

module csr_write_ctrl
    import csr_pkg::*;
(
    input  logic                    write_enable_i,
    input  logic                    kill_i,
    input  csr_op_e                 operation_i,
    input  csr_addr_t               address_i,
    input  xlen_t                   data_i,
    input  xlen_t                   current_i,     // Unmasked value of addressed CSR
    input  logic                    trap_event_i,
    output wr_strobe_t              wr_strobe_o,
    output logic [NUM_COUNTERS-1:0] cnt_wr_lo_o,
    output logic [NUM_COUNTERS-1:0] cnt_wr_hi_o,
    output xlen_t                   wr_data_o
);

    xlen_t                   mask;
    wr_strobe_t              reg_sel;
    logic [NUM_COUNTERS-1:0] lo_sel;
    logic [NUM_COUNTERS-1:0] hi_sel;
    logic                    write_ok;

    // Read-only and unknown addresses keep a zero mask and no select
    always_comb begin
        mask    = '0;
        reg_sel = '0;
        lo_sel  = '0;
        hi_sel  = '0;
        case (address_i)
            ADDR_MSTATUS:   begin mask = MASK_MSTATUS; reg_sel[WR_MSTATUS]  = 1'b1; end
            ADDR_MISA:      begin mask = MASK_MISA;    reg_sel[WR_MISA]     = 1'b1; end
            ADDR_MIE:       begin mask = MASK_MIE;     reg_sel[WR_MIE]      = 1'b1; end
            ADDR_MTVEC:     begin mask = MASK_ALIGN;   reg_sel[WR_MTVEC]    = 1'b1; end
            ADDR_MSCRATCH:  begin mask = MASK_FULL;    reg_sel[WR_MSCRATCH] = 1'b1; end
            ADDR_MEPC:      begin mask = MASK_ALIGN;   reg_sel[WR_MEPC]     = 1'b1; end
            ADDR_MCAUSE:    begin mask = MASK_FULL;    reg_sel[WR_MCAUSE]   = 1'b1; end
            ADDR_MTVAL:     begin mask = MASK_FULL;    reg_sel[WR_MTVAL]    = 1'b1; end
            ADDR_MCYCLE:    begin mask = MASK_FULL;    lo_sel[CNT_CYCLE]    = 1'b1; end
            ADDR_MCYCLEH:   begin mask = MASK_FULL;    hi_sel[CNT_CYCLE]    = 1'b1; end
            ADDR_MINSTRET:  begin mask = MASK_FULL;    lo_sel[CNT_INSTRET]  = 1'b1; end
            ADDR_MINSTRETH: begin mask = MASK_FULL;    hi_sel[CNT_INSTRET]  = 1'b1; end
            default: ;
        endcase
    end

    always_comb begin
        case (operation_i)
            CSR_SET:   wr_data_o = (current_i | data_i) & mask;
            CSR_CLEAR: wr_data_o = (current_i & ~data_i) & mask;
            default:   wr_data_o = data_i & mask;
        endcase
    end

    // Trap return, exception and acknowledge all win over a CSR write
    assign write_ok = write_enable_i && !kill_i && !trap_event_i;

    assign wr_strobe_o = reg_sel & {NUM_TRAP_REGS{write_ok}};
    assign cnt_wr_lo_o = lo_sel & {NUM_COUNTERS{write_ok}};
    assign cnt_wr_hi_o = hi_sel & {NUM_COUNTERS{write_ok}};

endmodule

// ==== testbench/csr_bank_chk.sv ====
// Bound assertions on read gating and the interrupt pending flag of the CSR bank
`timescale 1ns/1ns

module csr_bank_chk
    import csr_pkg::*;
(
    input logic  clk_i,
    input logic  reset_i,
    input logic  read_enable_i,
    input logic  kill_i,
    input logic  interrupt_ack_i,
    input xlen_t read_data_i,
    input logic  pending_i
);

    int unsigned fail_count = 0;   // Failure tally, read by the testbench

    read_gated: assert property (@(posedge clk_i)
        (!read_enable_i || kill_i) |-> (read_data_i == '0))
    else begin
        $error("Read data is not zero while the read is disabled or killed");
        fail_count++;
    end

    // Acknowledge blocks the flag for one cycle
    pending_after_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        interrupt_ack_i |=> !pending_i)
    else begin
        $error("Interrupt pending flag is high in the cycle after an acknowledge");
        fail_count++;
    end

    pending_after_reset: assert property (@(posedge clk_i) reset_i |=> !pending_i)
    else begin
        $error("Interrupt pending flag is high in the cycle after reset");
        fail_count++;
    end

endmodule

bind csr_bank_top csr_bank_chk u_chk (
    .clk_i, .reset_i, .read_enable_i, .kill_i, .interrupt_ack_i,
    .read_data_i (read_data_o),
    .pending_i   (interrupt_pending_o)
);

// ==== testbench/tb_csr_bank.sv ====
// Directed testbench for the CSR bank with clock, reset, test tasks, watchdog and report
`timescale 1ns/1ns

module tb_csr_bank
    import csr_pkg::*;
();

    logic      clk, reset, read_enable, write_enable, kill;
    logic      raise_exception, machine_return, interrupt_ack, jump;
    logic      interrupt_pending;
    csr_op_e   operation;
    csr_addr_t address;
    exc_code_t exception_code;
    xlen_t     wdata, pc, instruction, jump_target, irq;
    xlen_t     read_data, mtvec, mepc;
    dword_t    mtime;
    priv_e     privilege;
    integer    seed;
    int        errors;
    int        test_cycles = 160;   // Summed length of the directed tests

    csr_bank_top dut_i (
        .clk_i (clk), .reset_i (reset), .read_enable_i (read_enable),
        .write_enable_i (write_enable), .operation_i (operation), .address_i (address),
        .data_i (wdata), .kill_i (kill), .raise_exception_i (raise_exception),
        .exception_code_i (exception_code), .pc_i (pc), .instruction_i (instruction),
        .machine_return_i (machine_return), .interrupt_ack_i (interrupt_ack),
        .jump_i (jump), .jump_target_i (jump_target), .mtime_i (mtime), .irq_i (irq),
        .read_data_o (read_data), .interrupt_pending_o (interrupt_pending),
        .privilege_o (privilege), .mtvec_o (mtvec), .mepc_o (mepc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compare(string name, xlen_t got, xlen_t exp);
        assert (got == exp) else begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Address goes out on the rising edge, data is sampled at the falling edge
    task automatic read_csr(csr_addr_t addr, output xlen_t value);
        @(posedge clk);
        address <= addr;
        @(negedge clk);
        value = read_data;
    endtask

    task automatic expect_csr(csr_addr_t addr, xlen_t exp, string name);
        xlen_t value;
        read_csr(addr, value);
        compare(name, value, exp);
    endtask

    task automatic access_csr(csr_op_e op, csr_addr_t addr, xlen_t data, logic killed);
        @(posedge clk);
        operation    <= op;
        address      <= addr;
        wdata        <= data;
        kill         <= killed;
        write_enable <= 1'b1;
        @(posedge clk);   // Write lands on this edge
        write_enable <= 1'b0;
        kill         <= 1'b0;
    endtask

    task automatic pulse_exception(exc_code_t code, xlen_t pc_val, xlen_t instr);
        @(posedge clk);
        raise_exception <= 1'b1;
        exception_code  <= code;
        pc              <= pc_val;
        instruction     <= instr;
        @(posedge clk);
        raise_exception <= 1'b0;
    endtask

    task automatic verify_reset_state();
        expect_csr(ADDR_MISA, MISA_RESET, "read_data_o (misa)");
        expect_csr(ADDR_MSTATUS, '0, "read_data_o (mstatus)");
        expect_csr(ADDR_MIE, '0, "read_data_o (mie)");
        expect_csr(ADDR_MTVEC, '0, "read_data_o (mtvec)");
        expect_csr(ADDR_MEPC, '0, "read_data_o (mepc)");
        expect_csr(ADDR_MSCRATCH, '0, "read_data_o (mscratch)");
        compare("privilege_o", 32'(privilege), 32'(PRIV_MACHINE));
        compare("mtvec_o", mtvec, '0);
        compare("mepc_o", mepc, '0);
        @(posedge clk);
        read_enable <= 1'b0;
        address     <= ADDR_MISA;
        @(negedge clk);
        compare("read_data_o (enable low)", read_data, '0);
        @(posedge clk);
        read_enable <= 1'b1;
        kill        <= 1'b1;
        @(negedge clk);
        compare("read_data_o (killed)", read_data, '0);
        @(posedge clk);
        kill <= 1'b0;
        expect_csr(12'h7C0, '0, "read_data_o (unknown address)");
    endtask

    task automatic run_masked_ops();
        csr_addr_t addrs [5] = '{ADDR_MSCRATCH, ADDR_MTVEC, ADDR_MIE, ADDR_MISA, ADDR_MSTATUS};
        xlen_t     masks [5] = '{MASK_FULL, MASK_ALIGN, MASK_MIE, MASK_MISA, MASK_MSTATUS};
        xlen_t     model [5] = '{32'h0, 32'h0, 32'h0, MISA_RESET, 32'h0};
        int        idx;
        xlen_t     data;
        csr_op_e   op;
        repeat (20) begin
            idx  = {$random(seed)} % 5;
            data = $random(seed);
            case ({$random(seed)} % 3)
                0:       op = CSR_WRITE;
                1:       op = CSR_SET;
                default: op = CSR_CLEAR;
            endcase
            access_csr(op, addrs[idx], data, 1'b0);
            if (op == CSR_WRITE) model[idx] = data & masks[idx];
            else if (op == CSR_SET) model[idx] = (model[idx] | data) & masks[idx];
            else model[idx] = (model[idx] & ~data) & masks[idx];
            expect_csr(addrs[idx], model[idx], $sformatf("read_data_o (csr %h)", addrs[idx]));
        end
        compare("mtvec_o", mtvec, model[1]);
        access_csr(CSR_WRITE, ADDR_MSCRATCH, ~model[0], 1'b1);   // Killed write
        expect_csr(ADDR_MSCRATCH, model[0], "read_data_o (mscratch after kill)");
    endtask

    task automatic measure_counters();
        xlen_t  first, second, high;
        dword_t stamp;
        read_csr(ADDR_MCYCLE, first);
        repeat (9) @(posedge clk);
        read_csr(ADDR_MCYCLE, second);
        compare("mcycle delta over 10 cycles", second - first, 32'd10);
        high = $random(seed);
        access_csr(CSR_WRITE, ADDR_MCYCLEH, high, 1'b0);
        expect_csr(ADDR_MCYCLEH, high, "read_data_o (mcycleh)");
        expect_csr(ADDR_CYCLEH, high, "read_data_o (cycleh)");
        read_csr(ADDR_MCYCLE, first);
        expect_csr(ADDR_CYCLE, first + 32'd1, "read_data_o (cycle)");
        // Eight killed edges, with one counted edge on each side
        read_csr(ADDR_MINSTRET, first);
        @(posedge clk);
        kill <= 1'b1;
        repeat (8) @(posedge clk);
        kill <= 1'b0;
        expect_csr(ADDR_MINSTRET, first + 32'd2, "read_data_o (minstret)");
        stamp = {$random(seed), $random(seed)};
        @(posedge clk);
        mtime <= stamp;
        expect_csr(ADDR_TIME, stamp[31:0], "read_data_o (time)");
        expect_csr(ADDR_TIMEH, stamp[63:32], "read_data_o (timeh)");
    endtask

    task automatic take_exceptions();
        exc_code_t codes [3] = '{EXC_ILLEGAL, EXC_BREAKPOINT, EXC_ECALL_M};
        xlen_t     pc_val, instr, exp_mepc, exp_mtval;
        foreach (codes[i]) begin
            pc_val = $random(seed) & MASK_ALIGN;
            instr  = $random(seed);
            access_csr(CSR_WRITE, ADDR_MSTATUS, 32'h1 << BIT_MIE, 1'b0);
            pulse_exception(codes[i], pc_val, instr);
            exp_mepc  = (codes[i] == EXC_ECALL_M || codes[i] == EXC_BREAKPOINT) ?
                        pc_val : pc_val + 32'd4;
            exp_mtval = (codes[i] == EXC_ILLEGAL) ? instr : pc_val;
            expect_csr(ADDR_MCAUSE, 32'(codes[i]), "read_data_o (mcause)");
            expect_csr(ADDR_MEPC, exp_mepc, "read_data_o (mepc)");
            compare("mepc_o", mepc, exp_mepc);
            expect_csr(ADDR_MTVAL, exp_mtval, "read_data_o (mtval)");
            // MIE moved into MPIE, MPP records machine mode
            expect_csr(ADDR_MSTATUS, (32'h1 << BIT_MPIE) | (32'(PRIV_MACHINE) << MPP_LO),
                       "read_data_o (mstatus)");
            compare("privilege_o", 32'(privilege), 32'(PRIV_MACHINE));
        end
        access_csr(CSR_WRITE, ADDR_MSTATUS, 32'h1 << BIT_MPIE, 1'b0);   // MPP user, MIE off
        @(posedge clk);
        machine_return <= 1'b1;
        @(posedge clk);
        machine_return <= 1'b0;
        @(negedge clk);
        compare("privilege_o", 32'(privilege), 32'(PRIV_USER));
        expect_csr(ADDR_MSTATUS, (32'h1 << BIT_MPIE) | (32'h1 << BIT_MIE),
                   "read_data_o (mstatus after return)");
    endtask

    task automatic raise_interrupts();
        xlen_t target;
        target = $random(seed) & MASK_ALIGN;
        access_csr(CSR_WRITE, ADDR_MIE, MASK_MIE, 1'b0);
        access_csr(CSR_WRITE, ADDR_MSTATUS, 32'h1 << BIT_MIE, 1'b0);
        @(posedge clk);
        irq <= 32'h1 << IRQ_TIMER;
        repeat (2) @(negedge clk);
        compare("interrupt_pending_o", {31'b0, interrupt_pending}, 32'd0);
        @(negedge clk);
        compare("interrupt_pending_o", {31'b0, interrupt_pending}, 32'd1);
        @(posedge clk);
        irq <= (32'h1 << IRQ_EXT) | (32'h1 << IRQ_SW) | (32'h1 << IRQ_TIMER);
        repeat (2) @(posedge clk);   // mip takes all lines, then the code latches
        interrupt_ack <= 1'b1;
        jump          <= 1'b1;
        jump_target   <= target;
        @(posedge clk);
        interrupt_ack <= 1'b0;
        jump          <= 1'b0;
        irq           <= '0;
        @(negedge clk);
        compare("interrupt_pending_o", {31'b0, interrupt_pending}, 32'd0);
        compare("mepc_o", mepc, target);
        compare("privilege_o", 32'(privilege), 32'(PRIV_MACHINE));
        expect_csr(ADDR_MCAUSE, 32'h8000_0000 | 32'(IRQ_EXT), "read_data_o (mcause)");
        // Software line while only the timer is enabled
        access_csr(CSR_WRITE, ADDR_MIE, 32'h1 << IRQ_TIMER, 1'b0);
        access_csr(CSR_WRITE, ADDR_MSTATUS, 32'h1 << BIT_MIE, 1'b0);
        @(posedge clk);
        irq <= 32'h1 << IRQ_SW;
        repeat (6) begin
            @(negedge clk);
            compare("interrupt_pending_o", {31'b0, interrupt_pending}, 32'd0);
        end
        @(posedge clk);
        irq <= '0;
    endtask

    initial begin
        repeat (2 * test_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", 2 * test_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed            = 32'h4f97feff;
        errors          = 0;
        reset           = 1'b1;
        read_enable     = 1'b0;
        write_enable    = 1'b0;
        kill            = 1'b0;
        operation       = CSR_WRITE;
        address         = '0;
        wdata           = '0;
        raise_exception = 1'b0;
        exception_code  = '0;
        pc              = '0;
        instruction     = '0;
        machine_return  = 1'b0;
        interrupt_ack   = 1'b0;
        jump            = 1'b0;
        jump_target     = '0;
        mtime           = '0;
        irq             = '0;
        repeat (2) @(posedge clk);
        reset       <= 1'b0;
        read_enable <= 1'b1;
        verify_reset_state();
        run_masked_ops();
        measure_counters();
        take_exceptions();
        raise_interrupts();
        @(posedge clk);
        $display("Closing report: %0d check errors, %0d assertion failures",
                 errors, dut_i.u_chk.fail_count);
        if (errors == 0 && dut_i.u_chk.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
